/* axil_slave.sv */
// AXI-Lite single-beat slave that turns bus handshakes into one-cycle register strobes
`timescale 1ns/10ps
`default_nettype none

module axil_slave (
  input  logic                 clk_main_a0,
  input  logic                 rst_main_n_sync,
  // Write address, data and response channels
  input  logic                 awvalid,
  input  hello_pkg::addr_t     awaddr,
  output logic                 awready,
  input  logic                 wvalid,
  input  hello_pkg::data_t     wdata,
  output logic                 wready,
  output logic                 bvalid,
  output hello_pkg::axi_resp_e bresp,
  input  logic                 bready,
  // Read address and data channels
  input  logic                 arvalid,
  input  hello_pkg::addr_t     araddr,
  output logic                 arready,
  output logic                 rvalid,
  output hello_pkg::data_t     rdata,
  output hello_pkg::axi_resp_e rresp,
  input  logic                 rready,
  // Register side
  output logic                 reg_wr,
  output hello_pkg::addr_t     reg_wr_addr,
  output hello_pkg::data_t     reg_wr_data,
  output logic                 reg_rd,
  output hello_pkg::addr_t     reg_rd_addr,
  input  hello_pkg::data_t     rd_data
);

  hello_pkg::wr_state_e wr_state;
  hello_pkg::wr_state_e wr_state_nxt;
  hello_pkg::addr_t     wr_addr_q;
  hello_pkg::addr_t     rd_addr_q;
  logic                 rd_pend;
  logic                 aw_hs;
  logic                 w_hs;
  logic                 b_hs;
  logic                 ar_hs;
  logic                 r_hs;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign b_hs  = bvalid && bready;
  assign ar_hs = arvalid && arready;
  assign r_hs  = rvalid && rready;

  // --------------------
  // Write channel
  // --------------------
  always_comb begin
    wr_state_nxt = wr_state;
    case (wr_state)
      hello_pkg::WR_IDLE: if (aw_hs) wr_state_nxt = hello_pkg::WR_DATA;
      hello_pkg::WR_DATA: if (w_hs) wr_state_nxt = hello_pkg::WR_RESP;
      hello_pkg::WR_RESP: if (b_hs) wr_state_nxt = hello_pkg::WR_IDLE;
      default:            wr_state_nxt = hello_pkg::WR_IDLE;
    endcase
  end

  // awready is a flop so it stays low through reset
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= hello_pkg::WR_IDLE;
      awready  <= 1'b0;
    end else begin
      wr_state <= wr_state_nxt;
      awready  <= (wr_state_nxt == hello_pkg::WR_IDLE);
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr_q <= awaddr;
    end
  end

  assign wready      = (wr_state == hello_pkg::WR_DATA) && wvalid;
  assign bvalid      = (wr_state == hello_pkg::WR_RESP);
  assign bresp       = hello_pkg::RESP_OKAY;
  assign reg_wr      = w_hs;
  assign reg_wr_addr = wr_addr_q;
  assign reg_wr_data = wdata;

  // --------------------
  // Read channel
  // --------------------
  // One lookup cycle between AR and R, then hold until rready
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
      arready <= 1'b0;
    end else begin
      rd_pend <= ar_hs;
      if (rd_pend) begin
        rvalid <= 1'b1;
      end else if (r_hs) begin
        rvalid <= 1'b0;
      end
      arready <= !ar_hs && !rd_pend && (!rvalid || r_hs);
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_hs) begin
      rd_addr_q <= araddr;
    end
    if (rd_pend) begin
      rdata <= rd_data;
    end
  end

  assign reg_rd      = rd_pend;
  assign reg_rd_addr = rd_addr_q;
  assign rresp       = hello_pkg::RESP_OKAY;

endmodule

`default_nettype wire

/* cl_hello_top.sv */
// Top level of the hello-world design connecting the bus slave, registers, LED path and counter
`timescale 1ns/10ps
`default_nettype none

module cl_hello_top (
  input  logic                 clk_main_a0,
  input  logic                 rst_main_n_sync,
  input  logic                 awvalid,
  input  hello_pkg::addr_t     awaddr,
  output logic                 awready,
  input  logic                 wvalid,
  input  hello_pkg::data_t     wdata,
  output logic                 wready,
  output logic                 bvalid,
  output hello_pkg::axi_resp_e bresp,
  input  logic                 bready,
  input  logic                 arvalid,
  input  hello_pkg::addr_t     araddr,
  output logic                 arready,
  output logic                 rvalid,
  output hello_pkg::data_t     rdata,
  output hello_pkg::axi_resp_e rresp,
  input  logic                 rready,
  input  hello_pkg::led_t      vdip,
  output hello_pkg::led_t      vled
);

  // Register strobes
  logic             reg_wr;
  logic             reg_rd;
  hello_pkg::addr_t reg_wr_addr;
  hello_pkg::addr_t reg_rd_addr;
  hello_pkg::data_t reg_wr_data;
  hello_pkg::data_t rd_data;

  // LED path
  hello_pkg::led_t  hello_low;
  hello_pkg::led_t  led_shadow;

  // Counter control and status
  logic             cnt_enable;
  logic             cnt_oneshot;
  logic             cnt_load;
  logic             cnt_clear;
  hello_pkg::tick_t tick_value;
  hello_pkg::cnt_t  load_value;
  hello_pkg::cnt_t  watermark;
  hello_pkg::cnt_t  cnt_value;
  hello_pkg::tick_t cnt_tick_cnt;
  logic             cnt_ge_wmark;

  axil_slave u_axil_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .reg_wr          (reg_wr),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .reg_rd          (reg_rd),
    .reg_rd_addr     (reg_rd_addr),
    .rd_data         (rd_data)
  );

  cl_regs u_cl_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .reg_rd          (reg_rd),
    .reg_rd_addr     (reg_rd_addr),
    .rd_data         (rd_data),
    .led_shadow      (led_shadow),
    .cnt_value       (cnt_value),
    .cnt_tick_cnt    (cnt_tick_cnt),
    .cnt_ge_wmark    (cnt_ge_wmark),
    .hello_low       (hello_low),
    .cnt_enable      (cnt_enable),
    .cnt_oneshot     (cnt_oneshot),
    .cnt_load        (cnt_load),
    .cnt_clear       (cnt_clear),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark)
  );

  vled_mask u_vled_mask (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .vdip            (vdip),
    .led_shadow      (led_shadow),
    .vled            (vled)
  );

  tick_counter u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cnt_enable      (cnt_enable),
    .cnt_oneshot     (cnt_oneshot),
    .cnt_load        (cnt_load),
    .cnt_clear       (cnt_clear),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark),
    .cnt_value       (cnt_value),
    .cnt_tick_cnt    (cnt_tick_cnt),
    .cnt_ge_wmark    (cnt_ge_wmark)
  );

endmodule

`default_nettype wire

/* cl_regs.sv */
// Hello-world and counter-control register file with write decode and read-data mux
`timescale 1ns/10ps
`default_nettype none

`include "hello_macros.svh"

module cl_regs (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic             reg_wr,
  input  hello_pkg::addr_t reg_wr_addr,
  input  hello_pkg::data_t reg_wr_data,
  input  logic             reg_rd,
  input  hello_pkg::addr_t reg_rd_addr,
  output hello_pkg::data_t rd_data,
  input  hello_pkg::led_t  led_shadow,
  input  hello_pkg::cnt_t  cnt_value,
  input  hello_pkg::tick_t cnt_tick_cnt,
  input  logic             cnt_ge_wmark,
  output hello_pkg::led_t  hello_low,
  output logic             cnt_enable,
  output logic             cnt_oneshot,
  output logic             cnt_load,
  output logic             cnt_clear,
  output hello_pkg::tick_t tick_value,
  output hello_pkg::cnt_t  load_value,
  output hello_pkg::cnt_t  watermark
);

  hello_pkg::data_t hello_q;
  hello_pkg::data_t hello_swap;

  // --------------------
  // Register writes
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q     <= '0;
      cnt_enable  <= 1'b0;
      cnt_oneshot <= 1'b0;
      cnt_load    <= 1'b0;
      cnt_clear   <= 1'b0;
      tick_value  <= '0;
      load_value  <= '0;
      watermark   <= '0;
    end else begin
      // Load and clear are one-cycle pulses
      cnt_load  <= 1'b0;
      cnt_clear <= 1'b0;
      if (reg_wr) begin
        case (reg_wr_addr)
          hello_pkg::REG_HELLO: hello_q <= reg_wr_data;
          hello_pkg::REG_CNT_CTRL: begin
            cnt_enable  <= reg_wr_data[0];
            cnt_oneshot <= reg_wr_data[1];
            cnt_load    <= reg_wr_data[2];
            cnt_clear   <= reg_wr_data[3];
          end
          hello_pkg::REG_CNT_TICK:  tick_value <= reg_wr_data[`HELLO_TICK_W-1:0];
          hello_pkg::REG_CNT_LOAD:  load_value <= reg_wr_data[15:0];
          hello_pkg::REG_CNT_WMARK: watermark  <= reg_wr_data[15:0];
          default: ;
        endcase
      end
    end
  end

  assign hello_low  = hello_q[`HELLO_LED_W-1:0];

  // Hello word reads back with its byte order reversed
  assign hello_swap = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    rd_data = '0;
    if (reg_rd) begin
      case (reg_rd_addr)
        hello_pkg::REG_HELLO:     rd_data = hello_swap;
        hello_pkg::REG_VLED:      rd_data = {{(`HELLO_DATA_W-`HELLO_LED_W){1'b0}}, led_shadow};
        hello_pkg::REG_CNT_CTRL:  rd_data = {28'h0, cnt_clear, cnt_load, cnt_oneshot, cnt_enable};
        hello_pkg::REG_CNT_TICK:  rd_data = {24'h0, tick_value};
        hello_pkg::REG_CNT_LOAD:  rd_data = {16'h0, load_value};
        hello_pkg::REG_CNT_WMARK: rd_data = {16'h0, watermark};
        // Flag in the top bit, tick count above the event count
        hello_pkg::REG_CNT_VALUE: rd_data = {cnt_ge_wmark, 7'h0, cnt_tick_cnt, cnt_value};
        default:                  rd_data = `HELLO_UNIMPL_VALUE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hello_macros.svh */
// Bus, LED and prescaler widths plus the unmapped read value, included by the RTL and testbench
`ifndef HELLO_MACROS_SVH
`define HELLO_MACROS_SVH

// --------------------
// Bus widths
// --------------------
`define HELLO_DATA_W 32
`define HELLO_ADDR_W 32

// --------------------
// Virtual I/O and counter widths
// --------------------
`define HELLO_LED_W 16
`define HELLO_TICK_W 8

// Returned for any address outside the register map
`define HELLO_UNIMPL_VALUE 32'hdead_beef

`endif

/* hello_pkg.sv */
// Shared types and enums of the hello-world register design, referenced by scoped name
`default_nettype none

`include "hello_macros.svh"

package hello_pkg;

  // Bus payload types
  typedef logic [`HELLO_DATA_W-1:0] data_t;
  typedef logic [`HELLO_ADDR_W-1:0] addr_t;

  // Virtual I/O and counter types
  typedef logic [`HELLO_LED_W-1:0]  led_t;
  typedef logic [15:0]              cnt_t;
  typedef logic [`HELLO_TICK_W-1:0] tick_t;

  // Register map offsets
  typedef enum logic [31:0] {
    REG_HELLO     = 32'h0000_0500,
    REG_VLED      = 32'h0000_0504,
    REG_CNT_CTRL  = 32'h0000_0508,
    REG_CNT_TICK  = 32'h0000_050C,
    REG_CNT_LOAD  = 32'h0000_0510,
    REG_CNT_WMARK = 32'h0000_0514,
    REG_CNT_VALUE = 32'h0000_0518
  } reg_addr_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axi_resp_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

endpackage

`default_nettype wire

/* list.f */
+incdir+.
hello_pkg.sv
axil_slave.sv
cl_regs.sv
vled_mask.sv
tick_counter.sv
cl_hello_top.sv
tb_hello.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps --top-module tb_hello -f list.f \
  -o sim_hello > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_hello > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

/* tb_hello.sv */
// Self-checking testbench for the hello-world AXI-Lite design, compiled from list.f as top tb_hello
`timescale 1ns/10ps
`default_nettype none

`include "hello_macros.svh"

module tb_hello;

  localparam int WAIT_LIMIT = 50;
  localparam int POLL_LIMIT = 40;
  localparam logic [`HELLO_ADDR_W-1:0] HOLE_OFFSET = 'h100;

  logic                 clk_main_a0;
  logic                 rst_main_n_sync;
  logic                 awvalid;
  hello_pkg::addr_t     awaddr;
  logic                 awready;
  logic                 wvalid;
  hello_pkg::data_t     wdata;
  logic                 wready;
  logic                 bvalid;
  hello_pkg::axi_resp_e bresp;
  logic                 bready;
  logic                 arvalid;
  hello_pkg::addr_t     araddr;
  logic                 arready;
  logic                 rvalid;
  hello_pkg::data_t     rdata;
  hello_pkg::axi_resp_e rresp;
  logic                 rready;
  hello_pkg::led_t      vdip;
  hello_pkg::led_t      vled;

  // Model of the written registers
  hello_pkg::data_t hello_m;
  logic             enable_m;
  logic             oneshot_m;
  hello_pkg::tick_t tick_m;
  hello_pkg::cnt_t  load_m;
  hello_pkg::cnt_t  wmark_m;
  hello_pkg::cnt_t  cnt_m;

  // Read results waiting for the compare process
  hello_pkg::data_t     exp_q[$];
  hello_pkg::data_t     act_q[$];
  hello_pkg::axi_resp_e resp_q[$];
  event                 read_done;

  string test_name;
  int    seed;
  int    test_count;
  int    check_count;
  int    err_count;
  int    err_at_start;
  logic  abort;

  cl_hello_top dut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .vdip            (vdip),
    .vled            (vled)
  );

  always #20 clk_main_a0 = ~clk_main_a0;

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_word(input string name, input hello_pkg::data_t exp_word,
                            input hello_pkg::data_t act_word);
    check_count++;
    if (act_word !== exp_word) begin
      err_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp_word, act_word);
    end
  endtask

  task automatic check_leds(input string name, input hello_pkg::led_t exp_leds,
                            input hello_pkg::led_t act_leds);
    check_count++;
    if (act_leds !== exp_leds) begin
      err_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp_leds, act_leds);
    end
  endtask

  task automatic check_resp(input string name, input hello_pkg::axi_resp_e exp_resp,
                            input hello_pkg::axi_resp_e act_resp);
    check_count++;
    if (act_resp !== exp_resp) begin
      err_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp_resp, act_resp);
    end
  endtask

  task automatic report_timeout(input string what);
    err_count++;
    abort = 1'b1;
    $display("Test %s: no %s within %0d cycles", test_name, what, WAIT_LIMIT);
  endtask

  task automatic report_stall(input string what);
    err_count++;
    $display("Test %s: %s while the ready was held low", test_name, what);
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic hello_pkg::data_t expected_read(input hello_pkg::addr_t addr);
    hello_pkg::data_t word;
    word = '0;
    case (addr)
      hello_pkg::REG_HELLO: begin
        // Byte b of the read word is byte 3-b of the written word
        for (int b = 0; b < `HELLO_DATA_W / 8; b++) begin
          word[8*b +: 8] = hello_m[`HELLO_DATA_W-8-8*b +: 8];
        end
      end
      hello_pkg::REG_VLED:
        word = {{(`HELLO_DATA_W-`HELLO_LED_W){1'b0}}, hello_m[`HELLO_LED_W-1:0]};
      hello_pkg::REG_CNT_CTRL:  word = {30'h0, oneshot_m, enable_m};
      hello_pkg::REG_CNT_TICK:  word = {{(`HELLO_DATA_W-`HELLO_TICK_W){1'b0}}, tick_m};
      hello_pkg::REG_CNT_LOAD:  word = {16'h0, load_m};
      hello_pkg::REG_CNT_WMARK: word = {16'h0, wmark_m};
      // Prescaler sits at zero whenever these tests read the count
      hello_pkg::REG_CNT_VALUE: word = {(cnt_m >= wmark_m), 7'h0, 8'h0, cnt_m};
      default:                  word = `HELLO_UNIMPL_VALUE;
    endcase
    return word;
  endfunction

  function automatic void model_write(input hello_pkg::addr_t addr,
                                      input hello_pkg::data_t data);
    case (addr)
      hello_pkg::REG_HELLO: hello_m = data;
      hello_pkg::REG_CNT_CTRL: begin
        enable_m  = data[0];
        oneshot_m = data[1];
        // Clear beats load
        if (data[3]) begin
          cnt_m = '0;
        end else if (data[2]) begin
          cnt_m = load_m;
        end
      end
      hello_pkg::REG_CNT_TICK:  tick_m  = data[`HELLO_TICK_W-1:0];
      hello_pkg::REG_CNT_LOAD:  load_m  = data[15:0];
      hello_pkg::REG_CNT_WMARK: wmark_m = data[15:0];
      default: ;
    endcase
  endfunction

  // --------------------
  // Bus tasks
  // --------------------
  task automatic axil_write(input hello_pkg::addr_t addr, input hello_pkg::data_t data,
                            input int hold);
    int waits;
    if (abort) return;
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    bready  = 1'b0;
    waits   = 0;
    while (!awready && waits < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      waits++;
    end
    if (!awready) begin
      report_timeout("awready");
      awvalid = 1'b0;
      wvalid  = 1'b0;
      return;
    end
    // AW transfers on the coming rising edge
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    waits   = 0;
    while (!wready && waits < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      waits++;
    end
    if (!wready) begin
      report_timeout("wready");
      wvalid = 1'b0;
      return;
    end
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    waits  = 0;
    while (!bvalid && waits < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      waits++;
    end
    if (!bvalid) begin
      report_timeout("bvalid");
      return;
    end
    repeat (hold) begin
      @(negedge clk_main_a0);
      if (!bvalid) report_stall("bvalid dropped");
      if (awready) report_stall("awready rose");
    end
    check_resp(test_name, hello_pkg::RESP_OKAY, bresp);
    model_write(addr, data);
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  task automatic axil_read(input hello_pkg::addr_t addr, input int hold, input logic do_cmp,
                           output hello_pkg::data_t data);
    int waits;
    data = '0;
    if (abort) return;
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    rready  = 1'b0;
    waits   = 0;
    while (!arready && waits < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      waits++;
    end
    if (!arready) begin
      report_timeout("arready");
      arvalid = 1'b0;
      return;
    end
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    waits   = 0;
    while (!rvalid && waits < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      waits++;
    end
    if (!rvalid) begin
      report_timeout("rvalid");
      return;
    end
    data = rdata;
    repeat (hold) begin
      @(negedge clk_main_a0);
      if (!rvalid) report_stall("rvalid dropped");
      if (arready) report_stall("arready rose");
      check_word({test_name, " held rdata"}, data, rdata);
    end
    if (do_cmp) begin
      exp_q.push_back(expected_read(addr));
      act_q.push_back(rdata);
      resp_q.push_back(rresp);
      -> read_done;
    end
    rready = 1'b1;
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  task automatic read_check(input hello_pkg::addr_t addr, input int hold);
    hello_pkg::data_t word;
    axil_read(addr, hold, 1'b1, word);
  endtask

  // Compares every captured read against the model
  always begin
    @(read_done);
    while (act_q.size() > 0) begin
      check_word(test_name, exp_q.pop_front(), act_q.pop_front());
      check_resp(test_name, hello_pkg::RESP_OKAY, resp_q.pop_front());
    end
  end

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = err_count;
    test_count++;
  endtask

  task automatic end_test();
    if (err_count == err_at_start) begin
      $display("Test %0d %s: ok", test_count, test_name);
    end else begin
      $display("Test %0d %s: %0d errors", test_count, test_name, err_count - err_at_start);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    hello_pkg::data_t word;
    hello_pkg::led_t  dip_v;
    hello_pkg::led_t  led_exp;
    hello_pkg::cnt_t  load_v;
    int               rnd;
    int               waits;
    clk_main_a0     = 1'b0;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    vdip            = '0;
    hello_m         = '0;
    enable_m        = 1'b0;
    oneshot_m       = 1'b0;
    tick_m          = '0;
    load_m          = '0;
    wmark_m         = '0;
    cnt_m           = '0;
    seed            = 32'hbdc7e19a;
    test_count      = 0;
    check_count     = 0;
    err_count       = 0;
    err_at_start    = 0;
    abort           = 1'b0;
    repeat (8) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;

    start_test("hello_swap");
    rnd = $random(seed);
    axil_write(hello_pkg::REG_HELLO, rnd, 0);
    read_check(hello_pkg::REG_HELLO, 0);
    end_test();

    start_test("vled_shadow_and_holes");
    rnd = $random(seed);
    axil_write(hello_pkg::REG_HELLO, rnd, 0);
    read_check(hello_pkg::REG_VLED, 0);
    read_check(hello_pkg::REG_HELLO + HOLE_OFFSET, 0);
    read_check(hello_pkg::REG_CNT_VALUE + 32'h4, 0);
    end_test();

    start_test("vled_dip_mask");
    rnd     = $random(seed);
    dip_v   = rnd[`HELLO_LED_W-1:0];
    led_exp = hello_m[`HELLO_LED_W-1:0] & dip_v;
    @(negedge clk_main_a0);
    vdip  = dip_v;
    waits = 0;
    while (vled !== led_exp && waits < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      waits++;
    end
    check_leds(test_name, led_exp, vled);
    end_test();

    start_test("counter_load_clear");
    rnd    = $random(seed);
    load_v = rnd[15:0] & 16'h7fff;
    axil_write(hello_pkg::REG_CNT_LOAD, {16'h0, load_v}, 0);
    rnd = $random(seed);
    axil_write(hello_pkg::REG_CNT_WMARK, {16'h0, rnd[15:0]}, 0);
    axil_write(hello_pkg::REG_CNT_CTRL, 32'h4, 0);
    read_check(hello_pkg::REG_CNT_VALUE, 0);
    // Watermark equal to the count, then one above it
    axil_write(hello_pkg::REG_CNT_WMARK, {16'h0, load_v}, 0);
    read_check(hello_pkg::REG_CNT_VALUE, 0);
    axil_write(hello_pkg::REG_CNT_WMARK, {16'h0, load_v + 16'd1}, 0);
    read_check(hello_pkg::REG_CNT_VALUE, 0);
    axil_write(hello_pkg::REG_CNT_CTRL, 32'h8, 0);
    read_check(hello_pkg::REG_CNT_VALUE, 0);
    end_test();

    start_test("oneshot_saturate");
    axil_write(hello_pkg::REG_CNT_LOAD, 32'h0000_fff0, 0);
    axil_write(hello_pkg::REG_CNT_TICK, 32'h0, 0);
    axil_write(hello_pkg::REG_CNT_CTRL, 32'h4, 0);
    axil_write(hello_pkg::REG_CNT_CTRL, 32'h3, 0);
    word  = '0;
    waits = 0;
    while (word[15:0] !== 16'hffff && waits < POLL_LIMIT && !abort) begin
      axil_read(hello_pkg::REG_CNT_VALUE, 0, 1'b0, word);
      waits++;
    end
    if (word[15:0] !== 16'hffff) begin
      err_count++;
      $display("Test %s: count never reached ffff in %0d reads", test_name, POLL_LIMIT);
    end
    cnt_m = 16'hffff;
    repeat (3) begin
      repeat (10) @(negedge clk_main_a0);
      read_check(hello_pkg::REG_CNT_VALUE, 0);
    end
    axil_write(hello_pkg::REG_CNT_CTRL, 32'h0, 0);
    end_test();

    start_test("back_pressure");
    rnd = $random(seed);
    axil_write(hello_pkg::REG_HELLO, rnd, 6);
    read_check(hello_pkg::REG_HELLO, 6);
    read_check(hello_pkg::REG_VLED, 4);
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tick_counter.sv */
// Prescaling tick counter driving a 16-bit event counter with load, clear, oneshot and watermark
`timescale 1ns/10ps
`default_nettype none

module tick_counter (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic             cnt_enable,
  input  logic             cnt_oneshot,
  input  logic             cnt_load,
  input  logic             cnt_clear,
  input  hello_pkg::tick_t tick_value,
  input  hello_pkg::cnt_t  load_value,
  input  hello_pkg::cnt_t  watermark,
  output hello_pkg::cnt_t  cnt_value,
  output hello_pkg::tick_t cnt_tick_cnt,
  output logic             cnt_ge_wmark
);

  logic tick_wrap;
  logic cnt_sat;

  // Prescaler period is tick_value + 1 cycles
  assign tick_wrap = (cnt_tick_cnt >= tick_value);

  // Oneshot holds the count once it reaches all ones
  assign cnt_sat = cnt_oneshot && (cnt_value == '1);

  // --------------------
  // Prescaler
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_tick_cnt <= '0;
    end else if (cnt_clear) begin
      cnt_tick_cnt <= '0;
    end else if (cnt_enable) begin
      if (tick_wrap) begin
        cnt_tick_cnt <= '0;
      end else begin
        cnt_tick_cnt <= cnt_tick_cnt + 1'b1;
      end
    end
  end

  // --------------------
  // Event counter
  // --------------------
  // Clear wins over load, load wins over the enable hold
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cnt_value <= '0;
    end else if (cnt_clear) begin
      cnt_value <= '0;
    end else if (cnt_load) begin
      cnt_value <= load_value;
    end else if (cnt_enable && tick_wrap && !cnt_sat) begin
      cnt_value <= cnt_value + 1'b1;
    end
  end

  assign cnt_ge_wmark = (cnt_value >= watermark);

endmodule

`default_nettype wire

/* vled_mask.sv */
// Virtual LED path that shadows the hello low half and masks it with synchronized DIP switches
`timescale 1ns/10ps
`default_nettype none

module vled_mask (
  input  logic            clk_main_a0,
  input  logic            rst_main_n_sync,
  input  hello_pkg::led_t hello_low,
  input  hello_pkg::led_t vdip,
  output hello_pkg::led_t led_shadow,
  output hello_pkg::led_t vled
);

  hello_pkg::led_t vdip_q;
  hello_pkg::led_t vdip_q2;

  // --------------------
  // DIP synchronizer
  // --------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q  <= vdip;
      vdip_q2 <= vdip_q;
    end
  end

  // --------------------
  // LED shadow and output
  // --------------------
  // Shadow lags the hello register by one cycle, LEDs by two
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      led_shadow <= '0;
      vled       <= '0;
    end else begin
      led_shadow <= hello_low;
      vled       <= led_shadow & vdip_q2;
    end
  end

endmodule

`default_nettype wire
